// File: rvv_decode_pkg.sv
// shared types and sizing for the vector decode front end
// command queue entries are rvv_cmd_t, uop queue entries rvv_uop_t
// modules import this with a wildcard inside the body and use
// scoped names in their port lists
package rvv_decode_pkg;

  // commands looked at per cycle by the decode stage
  localparam int num_de_inst = 2;
  // uops pushed into the uop queue per cycle, at most
  localparam int num_de_uop = 4;
  // largest split, lmul of 8
  localparam int max_uops = 8;
  localparam int uop_index_width = 3;
  // wide enough for a split count of 1 to max_uops
  localparam int uop_count_width = $clog2(max_uops) + 1;
  // free slot count, 0 to num_de_uop
  localparam int slot_cnt_width = $clog2(num_de_uop + 1);

  localparam int cmd_queue_depth = 4;
  localparam int uop_queue_depth = 8;

  // integer vector funct3 encodings
  localparam logic [2:0] opivv = 3'b000;
  localparam logic [2:0] opivi = 3'b011;
  localparam logic [2:0] opivx = 3'b100;

  typedef struct packed {
    logic [5:0]  funct6;
    logic [2:0]  funct3;
    logic [4:0]  vd;
    logic [4:0]  vs1;
    logic [4:0]  vs2;
    logic [4:0]  imm5;
    logic [31:0] rs1_data;
    // split count is 2**lmul_log2
    logic [1:0]  lmul_log2;
  } rvv_cmd_t;

  typedef struct packed {
    logic [5:0]                 funct6;
    logic [2:0]                 funct3;
    logic [4:0]                 vd;
    logic [4:0]                 vs1;
    logic [4:0]                 vs2;
    // scalar or sign-extended immediate, zero for opivv
    logic [31:0]                operand;
    logic [uop_index_width-1:0] uop_index;
    logic                       last_uop;
  } rvv_uop_t;

endpackage

// File: rvv_multi_fifo.sv
// circular FIFO with several pushes and several pops per cycle
// push and pop are thermometer codes, bit 0 is the oldest slot
// head[i] shows the i-th oldest entry, valid while count > i
// almost_empty[k] is high with at most k entries held,
// almost_full[k] with at most k entries free
`timescale 1ns/1ps

module rvv_multi_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 4,
  parameter int  push_w    = 1,
  parameter int  pop_w     = 1
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic     [push_w-1:0] push,
  input  payload_t [push_w-1:0] push_data,
  input  logic     [pop_w-1:0]  pop,
  output payload_t [pop_w-1:0]  head,
  output logic                  empty,
  output logic                  full,
  output logic     [pop_w-1:0]  almost_empty,
  output logic     [push_w-1:0] almost_full
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic [cnt_w-1:0] push_cnt;
  logic [cnt_w-1:0] pop_cnt;

  // pointer arithmetic modulo depth
  function automatic logic [ptr_w-1:0] wrap(input int unsigned idx);
    return ptr_w'(idx % depth);
  endfunction

  // thermometer codes, so counting set bits is enough
  always_comb begin
    push_cnt = '0;
    pop_cnt  = '0;
    for (int i = 0; i < push_w; i++) begin
      push_cnt = push_cnt + cnt_w'(push[i]);
    end
    for (int i = 0; i < pop_w; i++) begin
      pop_cnt = pop_cnt + cnt_w'(pop[i]);
    end
  end

  // storage, written in consecutive slots from wr_ptr
  always_ff @(posedge clk) begin
    for (int i = 0; i < push_w; i++) begin
      if (push[i]) begin
        mem[wrap(wr_ptr + i)] <= push_data[i];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wrap(wr_ptr + push_cnt);
      rd_ptr <= wrap(rd_ptr + pop_cnt);
      count  <= count + push_cnt - pop_cnt;
    end
  end

  for (genvar i = 0; i < pop_w; i++) begin : g_head
    assign head[i]         = mem[wrap(rd_ptr + i)];
    assign almost_empty[i] = (int'(count) <= i);
  end

  for (genvar k = 0; k < push_w; k++) begin : g_almost_full
    assign almost_full[k] = (int'(count) >= depth - k);
  end

  assign empty = (count == '0);
  assign full  = (int'(count) == depth);

endmodule

// File: rvv_decode_unit.sv
// combinational split of one vector command into a bundle of uops
// the bundle covers uop indices uop_index_start to uop_index_start+3,
// clipped to the command's split count
// last_in_bundle flags that the final uop falls inside this bundle
`timescale 1ns/1ps

module rvv_decode_unit (
  input  logic                                         inst_valid,
  input  rvv_decode_pkg::rvv_cmd_t                     inst,
  input  logic [rvv_decode_pkg::uop_index_width-1:0]   uop_index_start,
  output logic [rvv_decode_pkg::num_de_uop-1:0]        uop_valid,
  output rvv_decode_pkg::rvv_uop_t
           [rvv_decode_pkg::num_de_uop-1:0]            uop_bundle,
  output logic                                         last_in_bundle
);

  import rvv_decode_pkg::*;

  logic                       legal;
  logic [uop_count_width-1:0] uop_count;
  logic [uop_count_width-1:0] bundle_end;
  logic [31:0]                operand;

  // only the three integer formats are decoded here
  assign legal = (inst.funct3 == opivv) ||
                 (inst.funct3 == opivi) ||
                 (inst.funct3 == opivx);

  // 1, 2, 4 or 8 uops
  assign uop_count = uop_count_width'(1) << inst.lmul_log2;

  // one past the highest index this bundle can hold
  assign bundle_end = uop_count_width'(uop_index_start) + uop_count_width'(num_de_uop);

  // illegal encoding is done at once, nothing to push
  assign last_in_bundle = !legal || (uop_count <= bundle_end);

  // operand select
  always_comb begin
    case (inst.funct3)
      opivx:   operand = inst.rs1_data;
      opivi:   operand = {{27{inst.imm5[4]}}, inst.imm5};
      default: operand = '0;
    endcase
  end

  for (genvar i = 0; i < num_de_uop; i++) begin : g_uop
    // absolute uop index within the command, up to 10
    logic [uop_count_width-1:0] idx;

    assign idx = uop_count_width'(uop_index_start) + uop_count_width'(i);

    // valid slots form a thermometer from slot 0
    assign uop_valid[i] = inst_valid && legal && (idx < uop_count);

    assign uop_bundle[i].funct6 = inst.funct6;
    assign uop_bundle[i].funct3 = inst.funct3;
    // register group walk, wraps past v31
    assign uop_bundle[i].vd  = inst.vd  + 5'(idx);
    assign uop_bundle[i].vs1 = inst.vs1 + 5'(idx);
    assign uop_bundle[i].vs2 = inst.vs2 + 5'(idx);
    assign uop_bundle[i].operand = operand;
    assign uop_bundle[i].uop_index = idx[uop_index_width-1:0];
    assign uop_bundle[i].last_uop = (idx == uop_count - 1'b1);
  end

endmodule

// File: rvv_decode_ctrl.sv
// merges the two decode units' bundles into the uop queue
// unit 0 holds the oldest command, unit 1 the one behind it
// uops are pushed in order as far as the uop queue has room;
// a command is popped once its last uop has been pushed
// a partly pushed command leaves its next index in uop_index_remain
`timescale 1ns/1ps

module rvv_decode_ctrl (
  input  logic                                       clk,
  input  logic                                       arst_n,
  input  logic [rvv_decode_pkg::num_de_inst-1:0]     inst_valid,
  input  logic [rvv_decode_pkg::num_de_inst-1:0][rvv_decode_pkg::num_de_uop-1:0] uop_valid,
  input  rvv_decode_pkg::rvv_uop_t
           [rvv_decode_pkg::num_de_inst-1:0][rvv_decode_pkg::num_de_uop-1:0] uop_bundle,
  input  logic [rvv_decode_pkg::num_de_inst-1:0]     last_in_bundle,
  input  logic                                       uop_full,
  input  logic [rvv_decode_pkg::num_de_uop-1:1]      uop_almost_full,
  output logic [rvv_decode_pkg::uop_index_width-1:0] uop_index_remain,
  output logic [rvv_decode_pkg::num_de_inst-1:0]     cmd_pop,
  output logic [rvv_decode_pkg::num_de_uop-1:0]      uop_push,
  output rvv_decode_pkg::rvv_uop_t [rvv_decode_pkg::num_de_uop-1:0] uop_push_data
);

  import rvv_decode_pkg::*;

  logic [slot_cnt_width-1:0]  free_slots;
  logic [slot_cnt_width-1:0]  valid_cnt0;
  logic [slot_cnt_width-1:0]  valid_cnt1;
  logic [slot_cnt_width-1:0]  push_cnt0;
  logic [slot_cnt_width-1:0]  push_cnt1;
  logic [slot_cnt_width-1:0]  room1;
  logic                       done0;
  logic                       done1;
  logic [uop_index_width-1:0] index_next;

  // free space from the queue flags, smallest matching k wins
  always_comb begin
    free_slots = slot_cnt_width'(num_de_uop);
    for (int k = num_de_uop - 1; k >= 1; k--) begin
      if (uop_almost_full[k]) free_slots = slot_cnt_width'(k);
    end
    if (uop_full) free_slots = '0;
  end

  // valid uops per unit
  always_comb begin
    valid_cnt0 = '0;
    valid_cnt1 = '0;
    for (int j = 0; j < num_de_uop; j++) begin
      valid_cnt0 = valid_cnt0 + slot_cnt_width'(uop_valid[0][j]);
      valid_cnt1 = valid_cnt1 + slot_cnt_width'(uop_valid[1][j]);
    end
  end

  // unit 0 first, clipped to the free space
  assign push_cnt0 = (valid_cnt0 < free_slots) ? valid_cnt0 : free_slots;
  assign done0     = inst_valid[0] && last_in_bundle[0] && (valid_cnt0 <= free_slots);

  // unit 1 only behind a finished unit 0 command
  assign room1     = free_slots - push_cnt0;
  assign push_cnt1 = !done0 ? '0 : (valid_cnt1 < room1) ? valid_cnt1 : room1;
  assign done1     = done0 && inst_valid[1] && last_in_bundle[1] && (valid_cnt1 <= room1);

  assign cmd_pop = {done1, done0};

  // pack unit 0 then unit 1 into consecutive slots
  always_comb begin
    uop_push      = '0;
    // idle slots just carry unit 0's bundle
    uop_push_data = uop_bundle[0];
    for (int j = 0; j < num_de_uop; j++) begin
      if (j < push_cnt0) begin
        uop_push[j]      = 1'b1;
        uop_push_data[j] = uop_bundle[0][j];
      end else if (j < push_cnt0 + push_cnt1) begin
        uop_push[j]      = 1'b1;
        uop_push_data[j] = uop_bundle[1][j - push_cnt0];
      end
    end
  end

  // where the oldest unfinished command resumes next cycle
  always_comb begin
    if (inst_valid[0] && !done0) begin
      index_next = uop_index_remain + uop_index_width'(push_cnt0);
    end else if (done0 && inst_valid[1] && !done1) begin
      // unit 1's command moves to the head next cycle
      index_next = uop_index_width'(push_cnt1);
    end else begin
      index_next = '0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      uop_index_remain <= '0;
    end else begin
      uop_index_remain <= index_next;
    end
  end

endmodule

// File: rvv_decode.sv
// decode stage between the command queue and the uop queue
// the two oldest commands are split side by side; unit 0 resumes
// a partly split command, unit 1 always starts a fresh one
// purely combinational from queue head to push and pop, apart from
// the carried uop index inside the controller
`timescale 1ns/1ps

module rvv_decode (
  input  logic                                      clk,
  input  logic                                      arst_n,
  input  rvv_decode_pkg::rvv_cmd_t [rvv_decode_pkg::num_de_inst-1:0] cmd_head,
  input  logic                                      cmd_empty,
  input  logic [rvv_decode_pkg::num_de_inst-1:1]    cmd_almost_empty,
  output logic [rvv_decode_pkg::num_de_inst-1:0]    cmd_pop,
  output logic [rvv_decode_pkg::num_de_uop-1:0]     uop_push,
  output rvv_decode_pkg::rvv_uop_t [rvv_decode_pkg::num_de_uop-1:0] uop_push_data,
  input  logic                                      uop_full,
  input  logic [rvv_decode_pkg::num_de_uop-1:1]     uop_almost_full
);

  import rvv_decode_pkg::*;

  logic     [num_de_inst-1:0]                 inst_valid;
  logic     [num_de_inst-1:0][num_de_uop-1:0] uop_valid;
  rvv_uop_t [num_de_inst-1:0][num_de_uop-1:0] uop_bundle;
  logic     [num_de_inst-1:0]                 last_in_bundle;
  logic     [uop_index_width-1:0]             uop_index_remain;

  // head entry i is present when more than i entries are held
  assign inst_valid[0] = !cmd_empty;

  for (genvar i = 1; i < num_de_inst; i++) begin : g_inst_valid
    assign inst_valid[i] = !(cmd_empty || (|cmd_almost_empty[i:1]));
  end

  for (genvar i = 0; i < num_de_inst; i++) begin : g_unit
    // only the oldest command can be partly split
    rvv_decode_unit decode_unit_i (
      .inst_valid      (inst_valid[i]),
      .inst            (cmd_head[i]),
      .uop_index_start ((i == 0) ? uop_index_remain : '0),
      .uop_valid       (uop_valid[i]),
      .uop_bundle      (uop_bundle[i]),
      .last_in_bundle  (last_in_bundle[i])
    );
  end

  rvv_decode_ctrl decode_ctrl_i (
    .clk              (clk),
    .arst_n           (arst_n),
    .inst_valid       (inst_valid),
    .uop_valid        (uop_valid),
    .uop_bundle       (uop_bundle),
    .last_in_bundle   (last_in_bundle),
    .uop_full         (uop_full),
    .uop_almost_full  (uop_almost_full),
    .uop_index_remain (uop_index_remain),
    .cmd_pop          (cmd_pop),
    .uop_push         (uop_push),
    .uop_push_data    (uop_push_data)
  );

endmodule

// File: rvv_decode_top.sv
// top level: command queue, decode stage, uop queue
// valid/ready on the command input and the uop output; the uop
// output is the uop queue head, so it holds until it is taken
`timescale 1ns/1ps

module rvv_decode_top (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     cmd_valid,
  input  rvv_decode_pkg::rvv_cmd_t cmd_data,
  output logic                     cmd_ready,
  output logic                     uop_valid,
  output rvv_decode_pkg::rvv_uop_t uop_data,
  input  logic                     uop_ready
);

  import rvv_decode_pkg::*;

  rvv_cmd_t [num_de_inst-1:0] cmd_head;
  logic                       cmd_empty;
  logic                       cmd_full;
  logic     [num_de_inst-1:0] cmd_almost_empty;
  logic     [num_de_inst-1:0] cmd_pop;
  logic     [num_de_uop-1:0]  uop_push;
  rvv_uop_t [num_de_uop-1:0]  uop_push_data;
  logic                       uop_empty;
  logic                       uop_full;
  logic     [num_de_uop-1:0]  uop_almost_full;

  assign cmd_ready = !cmd_full;
  assign uop_valid = !uop_empty;

  rvv_multi_fifo #(
    .payload_t (rvv_cmd_t),
    .depth     (cmd_queue_depth),
    .push_w    (1),
    .pop_w     (num_de_inst)
  ) cmd_queue_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .push         (cmd_valid && cmd_ready),
    .push_data    (cmd_data),
    .pop          (cmd_pop),
    .head         (cmd_head),
    .empty        (cmd_empty),
    .full         (cmd_full),
    .almost_empty (cmd_almost_empty),
    // single push, full is enough
    .almost_full  ()
  );

  rvv_decode decode_i (
    .clk              (clk),
    .arst_n           (arst_n),
    .cmd_head         (cmd_head),
    .cmd_empty        (cmd_empty),
    // bit 0 repeats cmd_empty
    .cmd_almost_empty (cmd_almost_empty[num_de_inst-1:1]),
    .cmd_pop          (cmd_pop),
    .uop_push         (uop_push),
    .uop_push_data    (uop_push_data),
    .uop_full         (uop_full),
    .uop_almost_full  (uop_almost_full[num_de_uop-1:1])
  );

  rvv_multi_fifo #(
    .payload_t (rvv_uop_t),
    .depth     (uop_queue_depth),
    .push_w    (num_de_uop),
    .pop_w     (1)
  ) uop_queue_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .push         (uop_push),
    .push_data    (uop_push_data),
    .pop          (uop_valid && uop_ready),
    .head         (uop_data),
    .empty        (uop_empty),
    .full         (uop_full),
    .almost_empty (),
    .almost_full  (uop_almost_full)
  );

endmodule

// File: rvv_decode_properties.sv
// protocol checks for the decode front end, bound into rvv_decode_top
// failures raise $error, and the count is read by the testbench
`timescale 1ns/1ps

module rvv_decode_properties (
  input logic                                    clk,
  input logic                                    arst_n,
  input logic                                    cmd_ready,
  input logic                                    cmd_empty,
  input logic [rvv_decode_pkg::num_de_inst-1:0]  cmd_almost_empty,
  input logic [rvv_decode_pkg::num_de_inst-1:0]  cmd_pop,
  input logic                                    uop_valid,
  input logic                                    uop_ready,
  input rvv_decode_pkg::rvv_uop_t                uop_data,
  input logic                                    uop_full,
  input logic [rvv_decode_pkg::num_de_uop-1:0]   uop_push
);

  int failures = 0;

  // idle outputs while in reset
  reset_state_a: assert property (@(posedge clk)
    !arst_n |-> !uop_valid && cmd_ready && uop_push == '0 && cmd_pop == '0)
    else begin
      failures++;
      $error("outputs not idle during reset");
    end

  // stalled output holds its data
  uop_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
    uop_valid && !uop_ready |=> uop_valid && $stable(uop_data))
    else begin
      failures++;
      $error("uop output changed while stalled");
    end

  // a full command queue takes nothing and only a pop frees a slot
  cmd_ready_a: assert property (@(posedge clk) disable iff (!arst_n)
    !cmd_ready |=> cmd_ready == $past(cmd_pop[0]))
    else begin
      failures++;
      $error("cmd_ready does not follow the command queue fill level");
    end

  // no push into a full uop queue
  no_push_full_a: assert property (@(posedge clk) disable iff (!arst_n)
    uop_full |-> uop_push == '0)
    else begin
      failures++;
      $error("uop pushed while the uop queue was full");
    end

  push_thermo_a: assert property (@(posedge clk) disable iff (!arst_n)
    (uop_push & (uop_push + 1'b1)) == '0)
    else begin
      failures++;
      $error("uop_push is not a thermometer code");
    end

  // pops limited by what the command queue holds
  pop_one_a: assert property (@(posedge clk) disable iff (!arst_n)
    cmd_pop[0] |-> !cmd_empty)
    else begin
      failures++;
      $error("command popped from an empty queue");
    end

  pop_two_a: assert property (@(posedge clk) disable iff (!arst_n)
    cmd_pop[1] |-> cmd_pop[0] && !cmd_almost_empty[1])
    else begin
      failures++;
      $error("two commands popped without two present");
    end

endmodule

bind rvv_decode_top rvv_decode_properties properties_i (
  .clk              (clk),
  .arst_n           (arst_n),
  .cmd_ready        (cmd_ready),
  .cmd_empty        (cmd_empty),
  .cmd_almost_empty (cmd_almost_empty),
  .cmd_pop          (cmd_pop),
  .uop_valid        (uop_valid),
  .uop_ready        (uop_ready),
  .uop_data         (uop_data),
  .uop_full         (uop_full),
  .uop_push         (uop_push)
);

// File: tb_rvv_decode.sv
// testbench for the vector decode front end
// random commands go in and the uop stream comes out, both sides with random stalls
// each accepted legal command is expanded by a reference model, and every uop
// taken at the output is checked against the model's oldest entry
// protocol checks sit in the bound properties module
`timescale 1ns/1ps

module tb_rvv_decode;

  import rvv_decode_pkg::*;

  localparam int num_cmds      = 300;
  localparam int wait_limit    = 20000;
  localparam int settle_cycles = 20;

  logic     clk;
  logic     arst_n;
  logic     cmd_valid;
  rvv_cmd_t cmd_data;
  logic     cmd_ready;
  logic     uop_valid;
  rvv_uop_t uop_data;
  logic     uop_ready;

  // expected uops, oldest first
  rvv_uop_t exp_q[$];
  int       sent;
  logic     running;

  rvv_decode_top dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd_data  (cmd_data),
    .cmd_ready (cmd_ready),
    .uop_valid (uop_valid),
    .uop_data  (uop_data),
    .uop_ready (uop_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    stop_on_failure($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  function automatic logic is_legal(input logic [2:0] f3);
    return (f3 == opivv) || (f3 == opivi) || (f3 == opivx);
  endfunction

  // roughly one in eight commands gets an illegal funct3
  function automatic rvv_cmd_t random_cmd();
    rvv_cmd_t c;
    c.funct6    = 6'($urandom);
    c.vd        = 5'($urandom);
    c.vs1       = 5'($urandom);
    c.vs2       = 5'($urandom);
    c.imm5      = 5'($urandom);
    c.rs1_data  = $urandom;
    c.lmul_log2 = 2'($urandom);
    if ($urandom_range(7, 0) == 0) begin
      do c.funct3 = 3'($urandom); while (is_legal(c.funct3));
    end else begin
      case ($urandom_range(2, 0))
        0:       c.funct3 = opivv;
        1:       c.funct3 = opivi;
        default: c.funct3 = opivx;
      endcase
    end
    return c;
  endfunction

  // reference split: 2**lmul_log2 uops, registers walk by the uop index
  task automatic expand_cmd(input rvv_cmd_t c);
    rvv_uop_t u;
    int       n;
    n = 1 << c.lmul_log2;
    for (int i = 0; i < n; i++) begin
      u.funct6    = c.funct6;
      u.funct3    = c.funct3;
      u.vd        = 5'((int'(c.vd) + i) % 32);
      u.vs1       = 5'((int'(c.vs1) + i) % 32);
      u.vs2       = 5'((int'(c.vs2) + i) % 32);
      u.uop_index = 3'(i);
      u.last_uop  = (i == n - 1);
      if (c.funct3 == opivx) u.operand = c.rs1_data;
      else if (c.funct3 == opivi) u.operand = int'($signed(c.imm5));
      else u.operand = '0;
      // illegal encodings add nothing
      if (is_legal(c.funct3)) exp_q.push_back(u);
    end
  endtask

  task automatic check_uop(input rvv_uop_t got);
    rvv_uop_t exp;
    if (exp_q.size() == 0) begin
      stop_on_failure("a uop came out with no accepted command expecting it");
    end else begin
      exp = exp_q.pop_front();
      assert (got.funct6 == exp.funct6)
        else report_mismatch("uop_data.funct6", got.funct6, exp.funct6);
      assert (got.funct3 == exp.funct3)
        else report_mismatch("uop_data.funct3", got.funct3, exp.funct3);
      assert (got.vd == exp.vd) else report_mismatch("uop_data.vd", got.vd, exp.vd);
      assert (got.vs1 == exp.vs1) else report_mismatch("uop_data.vs1", got.vs1, exp.vs1);
      assert (got.vs2 == exp.vs2) else report_mismatch("uop_data.vs2", got.vs2, exp.vs2);
      // opivv carries no operand worth checking
      assert (exp.funct3 == opivv || got.operand == exp.operand)
        else report_mismatch("uop_data.operand", got.operand, exp.operand);
      assert (got.uop_index == exp.uop_index)
        else report_mismatch("uop_data.uop_index", got.uop_index, exp.uop_index);
      assert (got.last_uop == exp.last_uop)
        else report_mismatch("uop_data.last_uop", got.last_uop, exp.last_uop);
    end
  endtask

  // sample at the edge, then drive the next cycle's inputs
  initial begin
    void'($urandom(26));
    forever begin
      @(posedge clk);
      if (running) begin
        if (cmd_valid && cmd_ready) begin
          expand_cmd(cmd_data);
          sent = sent + 1;
        end
        if (uop_valid && uop_ready) check_uop(uop_data);
        if (dut_i.properties_i.failures != 0) begin
          stop_on_failure("a protocol assertion failed in the bound checker");
        end
        // command held until taken
        if (!cmd_valid || cmd_ready) begin
          cmd_valid <= (sent < num_cmds) && ($urandom_range(3, 0) != 0);
          cmd_data  <= random_cmd();
        end
        uop_ready <= ($urandom_range(3, 0) != 0);
      end
    end
  end

  initial begin
    int cycles;
    arst_n    = 1'b0;
    cmd_valid = 1'b0;
    cmd_data  = '0;
    uop_ready = 1'b0;
    running   = 1'b0;
    sent      = 0;
    repeat (8) @(posedge clk);
    arst_n  <= 1'b1;
    running <= 1'b1;
    cycles = 0;
    while (sent < num_cmds && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (sent < num_cmds) stop_on_failure("timeout while the command input was stalled");
    cycles = 0;
    while (exp_q.size() != 0 && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) stop_on_failure("timeout before all expected uops came out");
    // stray uops in this window still hit check_uop
    repeat (settle_cycles) @(negedge clk);
    if (dut_i.properties_i.failures == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      stop_on_failure("a protocol assertion failed in the bound checker");
    end
  end

endmodule

// File: rvv_decode.f
rvv_decode_pkg.sv
rvv_multi_fifo.sv
rvv_decode_unit.sv
rvv_decode_ctrl.sv
rvv_decode.sv
rvv_decode_top.sv
rvv_decode_properties.sv
tb_rvv_decode.sv

// File: Makefile
TOP = tb_rvv_decode
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search the log for the pass line"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f rvv_decode.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
